/* include/fetch_defs.svh */
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// ******************************
// Cache geometry.
// ******************************
`define FETCH_OFFSET_BITS 4
`define FETCH_INDEX_BITS  2
`define FETCH_TAG_BITS    (32 - `FETCH_OFFSET_BITS - `FETCH_INDEX_BITS)
`define FETCH_LINES       (1 << `FETCH_INDEX_BITS)
`define FETCH_LINE_BITS   ((1 << `FETCH_OFFSET_BITS) * 8)

// AXI length for a four-beat line.
`define FETCH_BURST_LEN   8'd3

// ******************************
// Address map and traps.
// ******************************
`define FETCH_RESET_PC    32'h8000_0000
`define FETCH_SRAM_REGION 8'h0f
`define FETCH_TRAP_DELAY  4

`endif

/* design/fetch_pkg.sv */
`include "fetch_defs.svh"

package fetch_pkg;

  // One cache line.
  typedef struct packed {
    logic                         valid;
    logic [`FETCH_TAG_BITS-1:0]   tag;
    logic [`FETCH_LINE_BITS-1:0]  data;
  } line_t;

  // Burst read request toward memory.
  typedef struct packed {
    logic [31:0] addr;
    logic [7:0]  len;
  } read_req_t;

  // One returned data beat.
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } fill_beat_t;

  // Payload handed to decode.
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] inst;
  } fetch_out_t;

endpackage

/* design/icache_array.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module icache_array (
  input  logic                          clock,
  input  logic                          reset,
  input  logic                          flush,
  input  logic [`FETCH_INDEX_BITS-1:0]  lookup_index,
  input  logic [`FETCH_TAG_BITS-1:0]    lookup_tag,
  input  logic [1:0]                    word_select,
  input  logic                          fill_enable,
  input  logic [31:0]                   fill_data,
  output logic                          hit,
  output logic [31:0]                   hit_word
);

  fetch_pkg::line_t lines [`FETCH_LINES];
  fetch_pkg::line_t sel_line;

  assign sel_line = lines[lookup_index];

  // Lookup is purely combinational.
  assign hit      = sel_line.valid && (sel_line.tag == lookup_tag);
  assign hit_word = sel_line.data[word_select * 32 +: 32];

  // ******************************
  // Fill and flush.
  // ******************************
  always_ff @(posedge clock) begin
    if (fill_enable) begin
      // New beat enters at the top, older words move down.
      lines[lookup_index].data  <= {fill_data,
                                    sel_line.data[`FETCH_LINE_BITS-1:32]};
      lines[lookup_index].tag   <= lookup_tag;
      lines[lookup_index].valid <= 1'b1;
    end
    if (reset || flush) begin
      for (int i = 0; i < `FETCH_LINES; i++) begin
        lines[i].valid <= 1'b0;
      end
    end
  end

endmodule

/* design/line_refill.sv */
`timescale 1ns/1ps

module line_refill (
  input  logic                   clock,
  input  logic                   reset,
  input  fetch_pkg::read_req_t   req,
  input  logic                   req_start,
  input  logic                   arready,
  input  logic                   rvalid,
  input  logic [31:0]            rdata,
  input  logic                   rlast,
  output logic [31:0]            araddr,
  output logic [7:0]             arlen,
  output logic                   arvalid,
  output logic                   rready,
  output fetch_pkg::fill_beat_t  beat,
  output logic                   beat_valid,
  output logic                   refill_done
);

  typedef enum logic [1:0] {
    RF_IDLE,
    RF_ADDR,
    RF_DATA
  } refill_state_t;

  refill_state_t state;

  // ******************************
  // Burst FSM.
  // ******************************
  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= RF_IDLE;
      arvalid <= 1'b0;
      rready  <= 1'b0;
    end else begin
      case (state)
        RF_IDLE: begin
          if (req_start) begin
            state   <= RF_ADDR;
            arvalid <= 1'b1;
          end
        end
        RF_ADDR: begin
          if (arready) begin
            state   <= RF_DATA;
            arvalid <= 1'b0;
            rready  <= 1'b1;
          end
        end
        RF_DATA: begin
          if (rvalid && rlast) begin
            state  <= RF_IDLE;
            rready <= 1'b0;
          end
        end
        default: state <= RF_IDLE;
      endcase
    end
  end

  // Address held stable while arvalid is up.
  always_ff @(posedge clock) begin
    if (state == RF_IDLE && req_start) begin
      araddr <= req.addr;
      arlen  <= req.len;
    end
  end

  assign beat_valid  = rready && rvalid;
  assign beat.data   = rdata;
  assign beat.last   = rlast;
  assign refill_done = beat_valid && rlast;

endmodule

/* design/fetch_unit.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_unit (
  input  logic                          clock,
  input  logic                          reset,
  input  logic [31:0]                   npc,
  input  logic                          npc_valid,
  input  logic                          idu_ready,
  input  logic                          block,
  input  logic                          clear_pipeline,
  input  logic                          hit,
  input  logic [31:0]                   hit_word,
  input  fetch_pkg::fill_beat_t         beat,
  input  logic                          beat_valid,
  input  logic                          refill_done,
  output logic                          inst_valid,
  output fetch_pkg::fetch_out_t         fetch_out,
  output logic [`FETCH_INDEX_BITS-1:0]  lookup_index,
  output logic [`FETCH_TAG_BITS-1:0]    lookup_tag,
  output logic [1:0]                    word_select,
  output logic                          fill_enable,
  output fetch_pkg::read_req_t          req,
  output logic                          req_start,
  output logic                          enable,
  output logic                          inst_addr_misaligned
);

  localparam int DEPTH = `FETCH_TRAP_DELAY;
  localparam int OFF   = `FETCH_OFFSET_BITS;
  localparam int IDX   = `FETCH_INDEX_BITS;

  typedef enum logic {
    ST_LOOKUP,
    ST_WAIT
  } fetch_state_t;

  fetch_state_t     state;
  logic [31:0]      pc;
  logic [31:0]      miss_addr;
  logic [31:0]      cur_addr;
  logic             pipeline_empty;
  logic [DEPTH-1:0] trap_shift;
  logic [DEPTH-1:0] trap_next;
  logic             lookup_go;
  logic             pc_sram;
  logic             miss_sram;
  logic             cached_hit;
  logic             may_issue;
  logic             trap_set;
  logic             deliver_beat;

  assign pc_sram    = pc[31:24] == `FETCH_SRAM_REGION;
  assign miss_sram  = miss_addr[31:24] == `FETCH_SRAM_REGION;
  assign lookup_go  = (state == ST_LOOKUP) && !block && idu_ready && !clear_pipeline;
  assign cached_hit = hit && !pc_sram;

  // Only go to memory on a known-good path.
  assign may_issue = pipeline_empty || (npc_valid && npc == pc);
  assign req_start = lookup_go && !cached_hit && may_issue && pc[1:0] == 2'b00;
  assign trap_set  = lookup_go && !cached_hit && may_issue && pc[1:0] != 2'b00;

  // Line-aligned burst, or a single word in SRAM.
  assign req.addr = pc_sram ? pc : {pc[31:OFF], {OFF{1'b0}}};
  assign req.len  = pc_sram ? 8'd0 : `FETCH_BURST_LEN;

  // Cache port follows the miss address during a burst.
  assign cur_addr     = (state == ST_WAIT) ? miss_addr : pc;
  assign lookup_index = cur_addr[OFF+IDX-1:OFF];
  assign lookup_tag   = cur_addr[31:OFF+IDX];
  assign word_select  = cur_addr[3:2];

  assign fill_enable  = (state == ST_WAIT) && beat_valid && !miss_sram;
  // A redirect during an SRAM read drops the stale word.
  assign deliver_beat = (state == ST_WAIT) && beat_valid && miss_sram &&
                        pc == miss_addr && !clear_pipeline;

  assign enable               = state == ST_WAIT;
  assign inst_addr_misaligned = trap_shift[DEPTH-1];

  always_comb begin
    trap_next    = block ? trap_shift : {trap_shift[DEPTH-2:0], trap_shift[0]};
    trap_next[0] = trap_next[0] | trap_set;
  end

  // ******************************
  // State and pc.
  // ******************************
  always_ff @(posedge clock) begin
    if (reset) begin
      state <= ST_LOOKUP;
    end else if (req_start) begin
      state <= ST_WAIT;
    end else if (state == ST_WAIT && refill_done) begin
      state <= ST_LOOKUP;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      pc             <= `FETCH_RESET_PC;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      trap_shift     <= '0;
    end else if (clear_pipeline) begin
      pc             <= npc;
      inst_valid     <= 1'b0;
      pipeline_empty <= 1'b1;
      trap_shift     <= '0;
    end else begin
      trap_shift <= trap_next;
      if (lookup_go) begin
        inst_valid <= cached_hit;
        if (cached_hit) begin
          pc             <= pc + 32'd4;
          pipeline_empty <= 1'b0;
        end
      end else if (deliver_beat) begin
        inst_valid     <= 1'b1;
        pc             <= pc + 32'd4;
        pipeline_empty <= 1'b0;
      end
    end
  end

  // ******************************
  // Decode payload.
  // ******************************
  always_ff @(posedge clock) begin
    if (req_start) begin
      miss_addr <= pc;
    end
    if (lookup_go && cached_hit) begin
      fetch_out.pc   <= pc;
      fetch_out.inst <= hit_word;
    end else if (deliver_beat) begin
      fetch_out.pc   <= pc;
      fetch_out.inst <= beat.data;
    end else if (trap_set) begin
      fetch_out.pc <= pc;
    end
  end

endmodule

/* design/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_top (
  input  logic                   clock,
  input  logic                   reset,
  input  logic [31:0]            npc,
  input  logic                   npc_valid,
  input  logic                   idu_ready,
  input  logic                   block,
  input  logic                   clear_cache,
  input  logic                   clear_pipeline,
  input  logic                   arready,
  input  logic                   rvalid,
  input  logic [31:0]            rdata,
  input  logic [1:0]             rresp,
  input  logic                   rlast,
  output logic                   inst_valid,
  output fetch_pkg::fetch_out_t  fetch_out,
  output logic [31:0]            araddr,
  output logic [7:0]             arlen,
  output logic                   arvalid,
  output logic                   rready,
  output logic                   enable,
  output logic                   inst_addr_misaligned
);

  // Response code is not checked.

  logic [`FETCH_INDEX_BITS-1:0] lookup_index;
  logic [`FETCH_TAG_BITS-1:0]   lookup_tag;
  logic [1:0]                   word_select;
  logic                         fill_enable;
  logic                         hit;
  logic [31:0]                  hit_word;
  fetch_pkg::read_req_t         req;
  logic                         req_start;
  fetch_pkg::fill_beat_t        beat;
  logic                         beat_valid;
  logic                         refill_done;

  fetch_unit u_fetch_unit (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .idu_ready            (idu_ready),
    .block                (block),
    .clear_pipeline       (clear_pipeline),
    .hit                  (hit),
    .hit_word             (hit_word),
    .beat                 (beat),
    .beat_valid           (beat_valid),
    .refill_done          (refill_done),
    .inst_valid           (inst_valid),
    .fetch_out            (fetch_out),
    .lookup_index         (lookup_index),
    .lookup_tag           (lookup_tag),
    .word_select          (word_select),
    .fill_enable          (fill_enable),
    .req                  (req),
    .req_start            (req_start),
    .enable               (enable),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  icache_array u_icache_array (
    .clock        (clock),
    .reset        (reset),
    .flush        (clear_cache),
    .lookup_index (lookup_index),
    .lookup_tag   (lookup_tag),
    .word_select  (word_select),
    .fill_enable  (fill_enable),
    .fill_data    (beat.data),
    .hit          (hit),
    .hit_word     (hit_word)
  );

  line_refill u_line_refill (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .req_start   (req_start),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rlast       (rlast),
    .araddr      (araddr),
    .arlen       (arlen),
    .arvalid     (arvalid),
    .rready      (rready),
    .beat        (beat),
    .beat_valid  (beat_valid),
    .refill_done (refill_done)
  );

endmodule

/* dv/burst_mem_model.sv */
`timescale 1ns/1ps

module burst_mem_model (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] araddr,
  input  logic [7:0]  arlen,
  input  logic        arvalid,
  output logic        arready,
  output logic        rvalid,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rlast,
  input  logic        rready,
  output logic [31:0] burst_count
);

  localparam int LOG_DEPTH = 64;

  // Address and length of every accepted burst, in order.
  logic [31:0] addr_log [LOG_DEPTH];
  logic [7:0]  len_log  [LOG_DEPTH];
  integer      seed;

  function automatic logic [31:0] word_at(input logic [31:0] addr);
    return addr ^ 32'ha5a5_0000;
  endfunction

  // Stall for zero to three cycles.
  task automatic wait_random();
    int gap;
    gap = $random(seed) & 3;
    repeat (gap) begin
      @(posedge clock);
      #1;
    end
  endtask

  task automatic serve_burst();
    logic [31:0] addr;
    logic [7:0]  len;
    wait_random();
    arready = 1'b1;
    addr    = araddr;
    len     = arlen;
    @(posedge clock);
    #1;
    arready = 1'b0;
    if (burst_count < LOG_DEPTH) begin
      addr_log[burst_count[5:0]] = addr;
      len_log[burst_count[5:0]]  = len;
    end
    burst_count = burst_count + 32'd1;
    for (int beat = 0; beat <= int'(len); beat++) begin
      wait_random();
      rvalid = 1'b1;
      rdata  = word_at(addr);
      rlast  = (beat == int'(len));
      // Hold the beat until the master is ready.
      while (!rready) begin
        @(posedge clock);
        #1;
      end
      @(posedge clock);
      #1;
      rvalid = 1'b0;
      rlast  = 1'b0;
      addr   = addr + 32'd4;
    end
  endtask

  initial begin
    seed        = 32'h66e3_12e7;
    arready     = 1'b0;
    rvalid      = 1'b0;
    rdata       = '0;
    rresp       = 2'b00;
    rlast       = 1'b0;
    burst_count = '0;
    forever begin
      @(posedge clock);
      #1;
      if (!reset && arvalid) begin
        serve_burst();
      end
    end
  end

endmodule

/* dv/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_defs.svh"

module fetch_tb;

  localparam int          NUM_ROWS    = 7;
  localparam int          CYCLE_LIMIT = NUM_ROWS * 400;
  localparam logic [31:0] DATA_MASK   = 32'ha5a5_0000;

  typedef struct packed {
    logic [31:0] start_pc;
    logic [31:0] count;
    logic [31:0] bursts;
    logic [31:0] len;
    logic        redirect;
    logic        flush;
    logic        misaligned;
  } test_row_t;

  logic                  clock;
  logic                  reset;
  logic [31:0]           npc;
  logic                  npc_valid;
  logic                  idu_ready;
  logic                  block;
  logic                  clear_cache;
  logic                  clear_pipeline;
  logic                  arready;
  logic                  rvalid;
  logic [31:0]           rdata;
  logic [1:0]            rresp;
  logic                  rlast;
  logic                  inst_valid;
  fetch_pkg::fetch_out_t fetch_out;
  logic [31:0]           araddr;
  logic [7:0]            arlen;
  logic                  arvalid;
  logic                  rready;
  logic                  enable;
  logic                  inst_addr_misaligned;
  logic [31:0]           burst_count;

  test_row_t rows [NUM_ROWS];
  int        errors;
  int        cycle_count;

  fetch_top uut (
    .clock                (clock),
    .reset                (reset),
    .npc                  (npc),
    .npc_valid            (npc_valid),
    .idu_ready            (idu_ready),
    .block                (block),
    .clear_cache          (clear_cache),
    .clear_pipeline       (clear_pipeline),
    .arready              (arready),
    .rvalid               (rvalid),
    .rdata                (rdata),
    .rresp                (rresp),
    .rlast                (rlast),
    .inst_valid           (inst_valid),
    .fetch_out            (fetch_out),
    .araddr               (araddr),
    .arlen                (arlen),
    .arvalid              (arvalid),
    .rready               (rready),
    .enable               (enable),
    .inst_addr_misaligned (inst_addr_misaligned)
  );

  burst_mem_model u_mem (
    .clock       (clock),
    .reset       (reset),
    .araddr      (araddr),
    .arlen       (arlen),
    .arvalid     (arvalid),
    .arready     (arready),
    .rvalid      (rvalid),
    .rdata       (rdata),
    .rresp       (rresp),
    .rlast       (rlast),
    .rready      (rready),
    .burst_count (burst_count)
  );

  initial clock = 1'b0;
  always #4 clock = ~clock;

  // ******************************
  // Checks and stimulus.
  // ******************************
  task automatic compare_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic redirect_fetch(input test_row_t row);
    npc            = row.start_pc;
    npc_valid      = 1'b1;
    clear_pipeline = 1'b1;
    clear_cache    = row.flush;
    @(posedge clock);
    #1;
    clear_pipeline = 1'b0;
    clear_cache    = 1'b0;
    compare_value("inst_addr_misaligned", 32'(inst_addr_misaligned), 32'd0);
    compare_value("inst_valid", 32'(inst_valid), 32'd0);
  endtask

  // Decode stand-in that stays ready and confirms pc plus 4.
  task automatic collect_stream(input test_row_t row);
    logic [31:0] expected_pc;
    int          taken;
    expected_pc = row.start_pc;
    taken       = 0;
    while (taken < int'(row.count)) begin
      @(posedge clock);
      #1;
      // Busy exactly while an address or data phase is open.
      compare_value("enable", 32'(enable), 32'(arvalid || rready));
      if (inst_valid) begin
        compare_value("fetch_out.pc", fetch_out.pc, expected_pc);
        compare_value("fetch_out.inst", fetch_out.inst, expected_pc ^ DATA_MASK);
        npc         = fetch_out.pc + 32'd4;
        npc_valid   = 1'b1;
        expected_pc = expected_pc + 32'd4;
        taken++;
      end
    end
  endtask

  task automatic wait_for_trap(input test_row_t row);
    int cycles;
    cycles = 0;
    while (!inst_addr_misaligned && cycles < `FETCH_TRAP_DELAY + 8) begin
      @(posedge clock);
      #1;
      cycles++;
      compare_value("inst_valid", 32'(inst_valid), 32'd0);
      compare_value("enable", 32'(enable), 32'd0);
    end
    if (!inst_addr_misaligned) begin
      $display("Misaligned flag never rose after redirect to %h", row.start_pc);
      errors++;
    end else begin
      compare_value("trap delay", 32'(cycles), `FETCH_TRAP_DELAY);
      compare_value("ifu_pc", fetch_out.pc, row.start_pc);
    end
  endtask

  task automatic check_bursts(input test_row_t row, input int first);
    int          seen;
    logic [31:0] step;
    logic [31:0] addr;
    logic [5:0]  slot;
    seen = int'(burst_count) - first;
    step = (row.len == 32'd0) ? 32'd4 : 32'd16;
    compare_value("burst_count", 32'(seen), row.bursts);
    for (int k = 0; k < seen && k < int'(row.bursts); k++) begin
      slot = 6'(first + k);
      addr = u_mem.addr_log[slot];
      compare_value("araddr", addr, row.start_pc + 32'(k) * step);
      compare_value("arlen", 32'(u_mem.len_log[slot]), row.len);
      if (row.len != 32'd0) begin
        compare_value("araddr[3:0]", 32'(addr[3:0]), 32'd0);
      end
    end
  endtask

  task automatic run_row(input test_row_t row);
    int first;
    first = int'(burst_count);
    if (row.redirect) begin
      redirect_fetch(row);
    end
    if (row.misaligned) begin
      wait_for_trap(row);
    end else begin
      collect_stream(row);
    end
    check_bursts(row, first);
  endtask

  // ******************************
  // Test table.
  // ******************************
  task automatic load_table();
    // Columns are pc, count, bursts, arlen, redirect, flush, misaligned.
    rows[0] = '{32'h8000_0000, 32'd8,  32'd2, 32'd3, 1'b0, 1'b0, 1'b0};
    rows[1] = '{32'h8000_1000, 32'd16, 32'd4, 32'd3, 1'b1, 1'b0, 1'b0};
    rows[2] = '{32'h8000_1000, 32'd16, 32'd0, 32'd3, 1'b1, 1'b0, 1'b0};
    rows[3] = '{32'h8000_1000, 32'd16, 32'd4, 32'd3, 1'b1, 1'b1, 1'b0};
    rows[4] = '{32'h0f00_0100, 32'd4,  32'd4, 32'd0, 1'b1, 1'b0, 1'b0};
    rows[5] = '{32'h8000_0402, 32'd0,  32'd0, 32'd3, 1'b1, 1'b0, 1'b1};
    rows[6] = '{32'h8000_0040, 32'd8,  32'd2, 32'd3, 1'b1, 1'b0, 1'b0};
  endtask

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clock);
      cycle_count++;
    end
    $display("Timeout after %0d cycles, the fetch stream stopped making progress",
             cycle_count);
    $display("tests failed");
    $finish;
  end

  initial begin
    errors         = 0;
    reset          = 1'b1;
    npc            = '0;
    npc_valid      = 1'b0;
    idu_ready      = 1'b1;
    block          = 1'b0;
    clear_cache    = 1'b0;
    clear_pipeline = 1'b0;
    load_table();
    repeat (5) @(posedge clock);
    #1;
    compare_value("inst_valid", 32'(inst_valid), 32'd0);
    compare_value("arvalid", 32'(arvalid), 32'd0);
    compare_value("rready", 32'(rready), 32'd0);
    compare_value("enable", 32'(enable), 32'd0);
    compare_value("inst_addr_misaligned", 32'(inst_addr_misaligned), 32'd0);
    reset = 1'b0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_row(rows[r]);
    end
    $display("Run finished with %0d errors", errors);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

/* files.f */
+incdir+include
design/fetch_pkg.sv
design/icache_array.sv
design/line_refill.sv
design/fetch_unit.sv
design/fetch_top.sv
dv/burst_mem_model.sv
dv/fetch_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build with Verilator and run; status follows the testbench verdict.
verilator --binary --timing --timescale 1ns/1ps --top-module fetch_tb \
  -f files.f -o fetch_sim ||
  { echo "Verilator build failed"; exit 1; }
sim_out="$(./obj_dir/fetch_sim)"
echo "$sim_out"
echo "$sim_out" | grep -qx "all tests passed" && exit 0 || exit 1
